//--- hw/gpio_defines.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO subsystem constants
// Address map, pin counts and synchronizer depth
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef GPIO_DEFINES_SVH
`define GPIO_DEFINES_SVH

// Each bank occupies four words of address space
`define GPIO_BANK0_BASE 8'h00
`define GPIO_BANK1_BASE 8'h10

// Register offsets inside a bank
`define GPIO_DIR_OFFSET 8'h0
`define GPIO_VALUE_OFFSET 8'h4

// Pins per bank
`define GPIO_BANK0_PINS 8
`define GPIO_BANK1_PINS 4

// Flip-flops between a pad and the value register
`define GPIO_SYNC_STAGES 2

`endif

//--- hw/gpio_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO subsystem types
// Bus widths and register selectors
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "gpio_defines.svh"

package gpio_pkg;

    // APB address, wide enough for both banks and the unmapped space above them
    typedef logic [7:0] io_addr_t;

    // APB read and write data
    typedef logic [31:0] io_data_t;

    // Bank targeted by the current transfer, bank_none for an unmapped address
    typedef enum logic [1:0]
    {
        bank0,
        bank1,
        bank_none
    } gpio_bank_t;

    // Register inside a bank
    typedef enum logic
    {
        reg_dir,
        reg_value
    } gpio_reg_t;

endpackage

`default_nettype wire

//--- hw/synchronizer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Flip-flop synchronizer for any payload type
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module synchronizer #(
    parameter type T = logic,
    parameter int STAGES = 2
)
(
    input  wire logic clk,
    input  wire logic reset,
    input  wire T     d,
    output T          q
);

    // Stage 0 takes the asynchronous input, the last stage is considered stable
    T stages [STAGES];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < STAGES; i++)
                stages[i] <= '0;
        end
        else
        begin
            stages[0] <= d;
            for (int i = 1; i < STAGES; i++)
                stages[i] <= stages[i - 1];
        end
    end

    assign q = stages[STAGES - 1];

endmodule

`default_nettype wire

//--- hw/gpio_controller.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO bank
// Direction and output registers with synchronized pin inputs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_controller
    import gpio_pkg::*;
#(
    parameter int NUM_PINS = 8
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  write_en,
    input  wire gpio_reg_t             reg_sel,
    input  wire io_data_t              wdata,
    input  wire logic [NUM_PINS - 1:0] pin_in,
    output logic [NUM_PINS - 1:0]      pin_out,
    output logic [NUM_PINS - 1:0]      pin_oe,
    output logic [NUM_PINS - 1:0]      direction,
    output logic [NUM_PINS - 1:0]      pin_value
);

    // Payload type handed to the synchronizer
    typedef logic [NUM_PINS - 1:0] pin_vec_t;

    // Register update. The strobe is already qualified by bank at the top level,
    // so only the register offset is tested here
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            direction <= '0;
            pin_out <= '0;
        end
        else if (write_en)
        begin
            // Upper data bits beyond the pin count are discarded
            case (reg_sel)
                reg_dir:
                    direction <= wdata[NUM_PINS - 1:0];
                reg_value:
                    pin_out <= wdata[NUM_PINS - 1:0];
                default:
                    direction <= direction;
            endcase
        end
    end

    // A set direction bit turns the pad driver on at the chip level
    assign pin_oe = direction;

    // Pads change without reference to clk, so they pass through a flop chain
    // before the read path sees them.
    // Output pins read back their own driven level through the pad
    synchronizer #(
        .T      (pin_vec_t),
        .STAGES (`GPIO_SYNC_STAGES)
    ) pin_sync_inst (
        .clk   (clk),
        .reset (reset),
        .d     (pin_in),
        .q     (pin_value)
    );

endmodule

`default_nettype wire

//--- hw/apb_io_decode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB decode
// Turns APB transfers into bank register strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module apb_io_decode
    import gpio_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       reset,
    input  wire io_addr_t   paddr,
    input  wire logic       psel,
    input  wire logic       penable,
    input  wire logic       pwrite,
    input  wire io_data_t   pwdata,
    output gpio_bank_t      bank_sel,
    output gpio_reg_t       reg_sel,
    output logic            write_en,
    output logic            read_en,
    output logic            access,
    output io_data_t        wdata
);

    // Set once the current access phase has issued its strobe
    logic strobe_done;
    logic first_access;

    // Address match against the two register offsets of each bank
    always_comb
    begin
        bank_sel = bank_none;
        reg_sel = reg_dir;
        case (paddr)
            `GPIO_BANK0_BASE + `GPIO_DIR_OFFSET:
            begin
                bank_sel = bank0;
                reg_sel = reg_dir;
            end
            `GPIO_BANK0_BASE + `GPIO_VALUE_OFFSET:
            begin
                bank_sel = bank0;
                reg_sel = reg_value;
            end
            `GPIO_BANK1_BASE + `GPIO_DIR_OFFSET:
            begin
                bank_sel = bank1;
                reg_sel = reg_dir;
            end
            `GPIO_BANK1_BASE + `GPIO_VALUE_OFFSET:
            begin
                bank_sel = bank1;
                reg_sel = reg_value;
            end
            default:
            begin
                // Anything else falls into the unmapped space
                bank_sel = bank_none;
                reg_sel = reg_dir;
            end
        endcase
    end

    assign access = psel & penable;

    // The flag follows access with one cycle of delay, so it is clear exactly in
    // the first access cycle and drops again in the setup phase of the next transfer
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            strobe_done <= 1'b0;
        else
            strobe_done <= access;
    end

    assign first_access = access & ~strobe_done;

    // Writes to unmapped addresses are dropped here, reads still strobe so the
    // result stage can insert its wait state and return zero
    assign write_en = first_access & pwrite & (bank_sel != bank_none);
    assign read_en = first_access & ~pwrite;

    assign wdata = pwdata;

endmodule

`default_nettype wire

//--- hw/io_read_result.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB response stage
// Read data register, PREADY and PSLVERR
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module io_read_result
    import gpio_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire gpio_bank_t                    bank_sel,
    input  wire gpio_reg_t                     reg_sel,
    input  wire logic                          read_en,
    input  wire logic                          access,
    input  wire logic [`GPIO_BANK0_PINS - 1:0] dir0,
    input  wire logic [`GPIO_BANK0_PINS - 1:0] value0,
    input  wire logic [`GPIO_BANK1_PINS - 1:0] dir1,
    input  wire logic [`GPIO_BANK1_PINS - 1:0] value1,
    output io_data_t                           prdata,
    output logic                               pready,
    output logic                               pslverr
);

    io_data_t read_mux;
    io_data_t read_data;
    logic read_ready;

    // Zero-extended register selected by the current address.
    // Unmapped addresses read as zero
    always_comb
    begin
        read_mux = '0;
        case (bank_sel)
            bank0:
                read_mux[`GPIO_BANK0_PINS - 1:0] = (reg_sel == reg_dir) ? dir0 : value0;
            bank1:
                read_mux[`GPIO_BANK1_PINS - 1:0] = (reg_sel == reg_dir) ? dir1 : value1;
            default:
                read_mux = '0;
        endcase
    end

    // Capture happens in the first access cycle of a read, the flag holds the
    // data on the bus until the transfer ends
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            read_data <= '0;
            read_ready <= 1'b0;
        end
        else if (read_en)
        begin
            read_data <= read_mux;
            read_ready <= 1'b1;
        end
        else if (!access)
            read_ready <= 1'b0;
    end

    assign prdata = read_ready ? read_data : '0;

    // The read strobe cycle is the single wait state, every other access cycle completes
    assign pready = access & ~read_en;

    // Error only flagged in the completing cycle
    assign pslverr = pready & (bank_sel == bank_none);

endmodule

`default_nettype wire

//--- hw/gpio_subsystem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO subsystem top
// APB decode, two GPIO banks and the response stage
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_subsystem
    import gpio_pkg::*;
(
    input  wire logic                          clk,
    input  wire logic                          reset,
    input  wire io_addr_t                      paddr,
    input  wire logic                          psel,
    input  wire logic                          penable,
    input  wire logic                          pwrite,
    input  wire io_data_t                      pwdata,
    output io_data_t                           prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  wire logic [`GPIO_BANK0_PINS - 1:0] gpio0_in,
    output logic [`GPIO_BANK0_PINS - 1:0]      gpio0_out,
    output logic [`GPIO_BANK0_PINS - 1:0]      gpio0_oe,
    input  wire logic [`GPIO_BANK1_PINS - 1:0] gpio1_in,
    output logic [`GPIO_BANK1_PINS - 1:0]      gpio1_out,
    output logic [`GPIO_BANK1_PINS - 1:0]      gpio1_oe
);

    gpio_bank_t bank_sel;
    gpio_reg_t reg_sel;
    logic write_en;
    logic read_en;
    logic access;
    io_data_t wdata;

    // Per-bank write strobes
    logic write_en0;
    logic write_en1;

    logic [`GPIO_BANK0_PINS - 1:0] dir0;
    logic [`GPIO_BANK0_PINS - 1:0] value0;
    logic [`GPIO_BANK1_PINS - 1:0] dir1;
    logic [`GPIO_BANK1_PINS - 1:0] value1;

    apb_io_decode decode_inst (
        .clk      (clk),
        .reset    (reset),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .bank_sel (bank_sel),
        .reg_sel  (reg_sel),
        .write_en (write_en),
        .read_en  (read_en),
        .access   (access),
        .wdata    (wdata)
    );

    // Only the addressed bank sees the write
    assign write_en0 = write_en & (bank_sel == bank0);
    assign write_en1 = write_en & (bank_sel == bank1);

    gpio_controller #(
        .NUM_PINS (`GPIO_BANK0_PINS)
    ) bank0_inst (
        .clk       (clk),
        .reset     (reset),
        .write_en  (write_en0),
        .reg_sel   (reg_sel),
        .wdata     (wdata),
        .pin_in    (gpio0_in),
        .pin_out   (gpio0_out),
        .pin_oe    (gpio0_oe),
        .direction (dir0),
        .pin_value (value0)
    );

    gpio_controller #(
        .NUM_PINS (`GPIO_BANK1_PINS)
    ) bank1_inst (
        .clk       (clk),
        .reset     (reset),
        .write_en  (write_en1),
        .reg_sel   (reg_sel),
        .wdata     (wdata),
        .pin_in    (gpio1_in),
        .pin_out   (gpio1_out),
        .pin_oe    (gpio1_oe),
        .direction (dir1),
        .pin_value (value1)
    );

    io_read_result result_inst (
        .clk      (clk),
        .reset    (reset),
        .bank_sel (bank_sel),
        .reg_sel  (reg_sel),
        .read_en  (read_en),
        .access   (access),
        .dir0     (dir0),
        .value0   (value0),
        .dir1     (dir1),
        .value1   (value1),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

endmodule

`default_nettype wire

//--- testbench/gpio_subsystem_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// GPIO subsystem testbench
// Table-driven APB transfers checked against a register model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

`include "gpio_defines.svh"

module gpio_subsystem_tb
    import gpio_pkg::*;
;

    localparam int reset_cycles = 16;
    localparam int num_random = 24;

    localparam io_addr_t bank0_dir_addr = `GPIO_BANK0_BASE + `GPIO_DIR_OFFSET;
    localparam io_addr_t bank0_value_addr = `GPIO_BANK0_BASE + `GPIO_VALUE_OFFSET;
    localparam io_addr_t bank1_dir_addr = `GPIO_BANK1_BASE + `GPIO_DIR_OFFSET;
    localparam io_addr_t bank1_value_addr = `GPIO_BANK1_BASE + `GPIO_VALUE_OFFSET;

    typedef logic [`GPIO_BANK0_PINS - 1:0] pin_vec_t;
    typedef enum logic [1:0]
    {
        op_write,
        op_read,
        op_pins
    } op_t;

    // One table row: the stimulus and everything expected after it
    typedef struct packed
    {
        op_t                           op;
        io_addr_t                      addr;
        io_data_t                      data;
        io_data_t                      exp_data;
        logic                          exp_err;
        logic [`GPIO_BANK0_PINS - 1:0] exp_out0;
        logic [`GPIO_BANK0_PINS - 1:0] exp_oe0;
        logic [`GPIO_BANK1_PINS - 1:0] exp_out1;
        logic [`GPIO_BANK1_PINS - 1:0] exp_oe1;
    } entry_t;

    logic clk = 1'b0;
    logic reset;
    io_addr_t paddr;
    logic psel;
    logic penable;
    logic pwrite;
    io_data_t pwdata;
    io_data_t prdata;
    logic pready;
    logic pslverr;
    logic [`GPIO_BANK0_PINS - 1:0] gpio0_in;
    logic [`GPIO_BANK0_PINS - 1:0] gpio0_out;
    logic [`GPIO_BANK0_PINS - 1:0] gpio0_oe;
    logic [`GPIO_BANK1_PINS - 1:0] gpio1_in;
    logic [`GPIO_BANK1_PINS - 1:0] gpio1_out;
    logic [`GPIO_BANK1_PINS - 1:0] gpio1_oe;

    entry_t stim_table[$];
    integer seed;
    int cycle_count = 0;
    int cycle_limit;

    // Register model, updated while the table is built
    logic [`GPIO_BANK0_PINS - 1:0] m_dir0 = '0;
    logic [`GPIO_BANK0_PINS - 1:0] m_out0 = '0;
    logic [`GPIO_BANK0_PINS - 1:0] m_pins0 = '0;
    logic [`GPIO_BANK1_PINS - 1:0] m_dir1 = '0;
    logic [`GPIO_BANK1_PINS - 1:0] m_out1 = '0;
    logic [`GPIO_BANK1_PINS - 1:0] m_pins1 = '0;

    gpio_subsystem gpio_subsystem_inst (
        .clk       (clk),
        .reset     (reset),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .gpio0_in  (gpio0_in),
        .gpio0_out (gpio0_out),
        .gpio0_oe  (gpio0_oe),
        .gpio1_in  (gpio1_in),
        .gpio1_out (gpio1_out),
        .gpio1_oe  (gpio1_oe)
    );

    // 40 ns clock period
    always
    begin
        #20 clk = ~clk;
    end

    // Ends a run that stops making progress
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_data(input string name, input io_data_t expected, input io_data_t actual);
        if (actual !== expected)
        begin
            $display("error: time %0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_error(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("error: time %0t %s expected %b actual %b", $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "error flag mismatch");
        end
    endtask

    // Bank 1 vectors arrive zero-extended to the bank 0 width
    task automatic check_pins(input string name, input pin_vec_t expected, input pin_vec_t actual);
        if (actual !== expected)
        begin
            $display("error: time %0t %s expected 0x%02h actual 0x%02h",
                     $time, name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "pin mismatch");
        end
    endtask

    function automatic logic is_mapped(input io_addr_t addr);
        return (addr == bank0_dir_addr) || (addr == bank0_value_addr) ||
               (addr == bank1_dir_addr) || (addr == bank1_value_addr);
    endfunction

    // A value register reads the pin levels, never the output register
    function automatic io_data_t model_read(input io_addr_t addr);
        case (addr)
            bank0_dir_addr:   return io_data_t'(m_dir0);
            bank0_value_addr: return io_data_t'(m_pins0);
            bank1_dir_addr:   return io_data_t'(m_dir1);
            bank1_value_addr: return io_data_t'(m_pins1);
            default:          return '0;
        endcase
    endfunction

    // Appends one row and moves the model on by its effect
    task automatic add_entry(input op_t op, input io_addr_t addr, input io_data_t data);
        entry_t e;
        e = '0;
        e.op = op;
        e.addr = addr;
        e.data = data;
        case (op)
            op_write:
            begin
                e.exp_err = ~is_mapped(addr);
                case (addr)
                    bank0_dir_addr:   m_dir0 = data[`GPIO_BANK0_PINS - 1:0];
                    bank0_value_addr: m_out0 = data[`GPIO_BANK0_PINS - 1:0];
                    bank1_dir_addr:   m_dir1 = data[`GPIO_BANK1_PINS - 1:0];
                    bank1_value_addr: m_out1 = data[`GPIO_BANK1_PINS - 1:0];
                    default:          ;
                endcase
            end
            op_read:
            begin
                e.exp_err = ~is_mapped(addr);
                e.exp_data = model_read(addr);
            end
            default:
            begin
                // The base address names the bank whose pads change
                if (addr == `GPIO_BANK1_BASE)
                    m_pins1 = data[`GPIO_BANK1_PINS - 1:0];
                else
                    m_pins0 = data[`GPIO_BANK0_PINS - 1:0];
            end
        endcase
        e.exp_out0 = m_out0;
        e.exp_oe0 = m_dir0;
        e.exp_out1 = m_out1;
        e.exp_oe1 = m_dir1;
        stim_table.push_back(e);
    endtask

    task automatic build_directed();
        // Reset values
        add_entry(op_read, bank0_dir_addr, '0);
        add_entry(op_read, bank1_dir_addr, '0);
        // Direction registers keep only their pin count
        add_entry(op_write, bank0_dir_addr, 32'h0000_00a5);
        add_entry(op_read, bank0_dir_addr, '0);
        add_entry(op_write, bank1_dir_addr, 32'hffff_fff6);
        add_entry(op_read, bank1_dir_addr, '0);
        // Output registers, each bank on its own
        add_entry(op_write, bank0_value_addr, 32'h0000_003c);
        add_entry(op_write, bank1_value_addr, 32'h0000_0009);
        // Pad levels through the synchronizer
        add_entry(op_pins, `GPIO_BANK0_BASE, 32'h0000_005a);
        add_entry(op_pins, `GPIO_BANK1_BASE, 32'h0000_000c);
        add_entry(op_read, bank0_value_addr, '0);
        add_entry(op_read, bank1_value_addr, '0);
        // Unmapped space errors and changes nothing
        add_entry(op_write, 8'h08, 32'h0000_00ff);
        add_entry(op_read, 8'h08, '0);
        add_entry(op_read, 8'h20, '0);
        add_entry(op_write, 8'h20, 32'h0000_0003);
        add_entry(op_read, bank0_dir_addr, '0);
        add_entry(op_read, bank1_dir_addr, '0);
    endtask

    task automatic build_random();
        io_addr_t addr_list[6];
        int pick;
        int slot;
        io_data_t data;
        addr_list = '{bank0_dir_addr, bank0_value_addr, bank1_dir_addr, bank1_value_addr,
                      8'h08, 8'h20};
        for (int i = 0; i < num_random; i++)
        begin
            pick = int'($unsigned($random(seed)) % 3);
            slot = int'($unsigned($random(seed)) % 6);
            data = $random(seed);
            if (pick == 0)
                add_entry(op_write, addr_list[slot], data);
            else if (pick == 1)
                add_entry(op_read, addr_list[slot], data);
            else
                add_entry(op_pins, data[31] ? `GPIO_BANK1_BASE : `GPIO_BANK0_BASE, data);
        end
    endtask

    // Setup phase, then access phase until the DUT raises pready
    task automatic apb_transfer(input logic write, input io_addr_t addr, input io_data_t data,
                                output io_data_t rdata, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= write;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        // Writes complete in the first access cycle, reads hold pready low for one wait state
        check_error("pready", write, pready);
        if (!write)
        begin
            @(negedge clk);
            check_error("pready", 1'b1, pready);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    // New pad levels, then long enough for the synchronizer to pass them on
    task automatic drive_pins(input io_addr_t addr, input io_data_t data);
        @(posedge clk);
        if (addr == `GPIO_BANK1_BASE)
            gpio1_in <= data[`GPIO_BANK1_PINS - 1:0];
        else
            gpio0_in <= data[`GPIO_BANK0_PINS - 1:0];
        repeat (4) @(posedge clk);
    endtask

    task automatic apply_entry(input entry_t e);
        io_data_t rdata;
        logic err;
        case (e.op)
            op_write:
            begin
                apb_transfer(1'b1, e.addr, e.data, rdata, err);
                check_error("pslverr", e.exp_err, err);
            end
            op_read:
            begin
                apb_transfer(1'b0, e.addr, '0, rdata, err);
                check_data("prdata", e.exp_data, rdata);
                check_error("pslverr", e.exp_err, err);
            end
            default:
                drive_pins(e.addr, e.data);
        endcase
        // Pin ports are sampled half a cycle after the edge that set them
        @(negedge clk);
        check_pins("gpio0_out", pin_vec_t'(e.exp_out0), pin_vec_t'(gpio0_out));
        check_pins("gpio0_oe", pin_vec_t'(e.exp_oe0), pin_vec_t'(gpio0_oe));
        check_pins("gpio1_out", pin_vec_t'(e.exp_out1), pin_vec_t'(gpio1_out));
        check_pins("gpio1_oe", pin_vec_t'(e.exp_oe1), pin_vec_t'(gpio1_oe));
    endtask

    initial
    begin
        seed = 67;
        reset <= 1'b1;
        paddr <= '0;
        psel <= 1'b0;
        penable <= 1'b0;
        pwrite <= 1'b0;
        pwdata <= '0;
        gpio0_in <= '0;
        gpio1_in <= '0;
        build_directed();
        build_random();
        cycle_limit = stim_table.size() * 8 + reset_cycles;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
        // Bus response and every pad driver are idle straight out of reset
        @(negedge clk);
        check_error("pready", 1'b0, pready);
        check_error("pslverr", 1'b0, pslverr);
        check_data("prdata", '0, prdata);
        check_pins("gpio0_out", '0, pin_vec_t'(gpio0_out));
        check_pins("gpio0_oe", '0, pin_vec_t'(gpio0_oe));
        check_pins("gpio1_out", '0, pin_vec_t'(gpio1_out));
        check_pins("gpio1_oe", '0, pin_vec_t'(gpio1_oe));
        for (int i = 0; i < stim_table.size(); i++)
            apply_entry(stim_table[i]);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hw
hw/gpio_pkg.sv
hw/synchronizer.sv
hw/gpio_controller.sv
hw/apb_io_decode.sv
hw/io_read_result.sv
hw/gpio_subsystem.sv
testbench/gpio_subsystem_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = gpio_subsystem_tb
FILELIST = src.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
